// ==== files.f ====
+incdir+hdl
hdl/mpArithPkg.sv
hdl/mpStagePkg.sv
hdl/operandPrep.sv
hdl/carrySelectAdder.sv
hdl/reductionPrep.sv
hdl/resultSelect.sv
hdl/mpModAdder.sv
testbench/mpModAdder_assert.sv
testbench/mpModAdderChecker.sv
testbench/mpModAdderTb.sv

// ==== Bender.yml ====
package:
  name: mp_mod_adder

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mpArithPkg.sv
      - hdl/mpStagePkg.sv
      - hdl/operandPrep.sv
      - hdl/carrySelectAdder.sv
      - hdl/reductionPrep.sv
      - hdl/resultSelect.sv
      - hdl/mpModAdder.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/mpModAdder_assert.sv
      - testbench/mpModAdderChecker.sv
      - testbench/mpModAdderTb.sv

// ==== testbench/mpModAdderTb.sv ====
`include "mp_settings.svh"

module mpModAdderTb;

  import mpArithPkg::*;

  logic        clk;
  logic        rstN;
  logic        start;
  opT          op;
  wordT        a;
  wordT        b;
  wordT        modulus;
  logic        done;
  wordT        result;

  logic [31:0] lcgState;
  int          valueErrors;
  int          timingErrors;
  int          pending;
  int          checked;
  int          otherErrors;
  int          issued;
  wordT        n;
  wordT        opX;
  wordT        opY;

  bind mpModAdder mpModAdderAssert uAssert
  (
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .done   (done),
    .result (result)
  );

  mpModAdder u_dut
  (
    .clk     (clk),
    .rstN    (rstN),
    .start   (start),
    .op      (op),
    .a       (a),
    .b       (b),
    .modulus (modulus),
    .done    (done),
    .result  (result)
  );

  mpModAdderChecker uCheck
  (
    .clk          (clk),
    .rstN         (rstN),
    .start        (start),
    .op           (op),
    .a            (a),
    .b            (b),
    .modulus      (modulus),
    .done         (done),
    .result       (result),
    .valueErrors  (valueErrors),
    .timingErrors (timingErrors),
    .pending      (pending),
    .checked      (checked)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic wordT randWord();
    wordT w;
    for (int i = 0; i < `MP_WIDTH / 32; i++)
      w[i*32 +: 32] = nextRand();
    return w;
  endfunction

  function automatic wordT randModulus();
    wordT m;
    m = randWord();
    m[`MP_WIDTH-1] = 1'b1;  // Full-width modulus.
    return m;
  endfunction

  function automatic wordT randBelow(input wordT m);
    wordT w;
    w = randWord();
    while (w >= m)
      w = w - m;
    return w;
  endfunction

  task automatic sendOp(input opT o, input wordT x, input wordT y, input wordT m);
    @(posedge clk);
    start   <= 1'b1;
    op      <= o;
    a       <= x;
    b       <= y;
    modulus <= m;
    issued++;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      start <= 1'b0;
    end
  endtask

  task automatic waitDrain(input int limit);
    int i;
    i = 0;
    while (pending != 0 && i < limit)
    begin
      @(negedge clk);
      i++;
    end
    if (pending != 0)
    begin
      otherErrors++;
      $display("Timeout: %0d results still outstanding after %0d cycles.", pending, limit);
    end
  endtask

  initial
  begin
    clk         = 1'b0;
    rstN        = 1'b0;
    start       = 1'b0;
    op          = OP_ADD;
    a           = '0;
    b           = '0;
    modulus     = '0;
    lcgState    = 32'h61f7;
    otherErrors = 0;
    issued      = 0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;

    // Pipeline must stay empty before the first start.
    repeat (3)
    begin
      @(negedge clk);
      if (done !== 1'b0 || {u_dut.prepValid, u_dut.uSum.validQ, u_dut.sumValid,
          u_dut.corrValid, u_dut.uReduce.validQ, u_dut.redValid} !== 6'b0)
      begin
        otherErrors++;
        $display("[FAIL] %0t: done or a valid bit is high after reset", $time);
      end
    end

    // Corner cases for long carry ripples.
    n = randModulus();
    sendOp(OP_ADD, '0, '0, n);
    sendOp(OP_SUB, '0, '0, n);
    sendOp(OP_ADD, n - 1, n - 1, n);
    sendOp(OP_SUB, '0, 1, n);
    sendOp(OP_ADD, n - 1, '0, n);
    sendOp(OP_SUB, n - 1, '0, n);
    sendOp(OP_ADD, '1 - 1, '1 - 1, '1);
    idle(1);
    waitDrain(20);

    for (int i = 0; i < 24; i++)
    begin
      n   = randModulus();
      opX = randBelow(n);
      opY = randBelow(n);
      sendOp(OP_ADD, opX, opY, n);
      idle(nextRand() % 3);
    end
    idle(1);
    waitDrain(20);

    for (int i = 0; i < 24; i++)
    begin
      n   = randModulus();
      opX = randBelow(n);
      opY = randBelow(n);
      sendOp(OP_SUB, opX, opY, n);
      idle(nextRand() % 3);
    end
    idle(1);
    waitDrain(20);

    // Back-to-back burst with mixed modes.
    for (int i = 0; i < 16; i++)
    begin
      n   = randModulus();
      opX = randBelow(n);
      opY = randBelow(n);
      sendOp(nextRand() % 2 ? OP_SUB : OP_ADD, opX, opY, n);
    end
    idle(1);
    waitDrain(30);

    idle(10);  // Catches any stray done.
    @(negedge clk);
    if (checked != issued)
    begin
      otherErrors++;
      $display("Issued %0d operations but only %0d results were checked.", issued, checked);
    end
    $display("Errors: value %0d, timing %0d, assertion %0d, other %0d", valueErrors,
             timingErrors, u_dut.uAssert.failCount, otherErrors);
    if (valueErrors + timingErrors + u_dut.uAssert.failCount + otherErrors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== testbench/mpModAdderChecker.sv ====
`include "mp_settings.svh"

module mpModAdderChecker
(
  input  logic             clk,
  input  logic             rstN,
  input  logic             start,
  input  mpArithPkg::opT   op,
  input  mpArithPkg::wordT a,
  input  mpArithPkg::wordT b,
  input  mpArithPkg::wordT modulus,
  input  logic             done,
  input  mpArithPkg::wordT result,
  output int               valueErrors,
  output int               timingErrors,
  output int               pending,
  output int               checked
);

  import mpArithPkg::*;

  typedef struct
  {
    wordT value;
    int   due;  // Cycle on which done is expected.
    int   id;
  } expT;

  expT expQ[$];
  expT entry;
  int  cycle;
  int  opCount;

  function automatic wordT modRef(input opT o, input wordT x, input wordT y, input wordT n);
    extWordT wide;
    if (o == OP_ADD)
    begin
      wide = {1'b0, x} + {1'b0, y};
      if (wide >= {1'b0, n})
        wide = wide - {1'b0, n};
    end
    else if (x >= y)
      wide = {1'b0, x} - {1'b0, y};
    else
      wide = {1'b0, x} + {1'b0, n} - {1'b0, y};  // Negative difference wraps by n.
    return wide[`MP_WIDTH-1:0];
  endfunction

  initial
  begin
    valueErrors  = 0;
    timingErrors = 0;
    pending      = 0;
    checked      = 0;
    cycle        = 0;
    opCount      = 0;
  end

  always @(posedge clk)
  begin
    cycle++;
    if (rstN && done)
    begin
      if (expQ.size() == 0)
      begin
        timingErrors++;
        $display("Unexpected done at time %0t with no operation in flight.", $time);
      end
      else
      begin
        entry = expQ.pop_front();
        if (entry.due != cycle)
        begin
          timingErrors++;
          $display("done for operation %0d came on cycle %0d instead of cycle %0d.",
                   entry.id, cycle, entry.due);
        end
        else
        begin
          checked++;
          if (result !== entry.value)
          begin
            valueErrors++;
            $display("[FAIL] %0t: operation %0d result low word %h, expected %h",
                     $time, entry.id, result[63:0], entry.value[63:0]);
          end
        end
      end
    end
    // Head of queue is overdue.
    if (expQ.size() != 0 && expQ[0].due < cycle)
    begin
      entry = expQ.pop_front();
      timingErrors++;
      $display("No done for operation %0d on cycle %0d; it is missing or late.",
               entry.id, entry.due);
    end
    if (rstN && start)
    begin
      entry.value = modRef(op, a, b, modulus);
      entry.due   = cycle + `MP_LATENCY;
      entry.id    = opCount;
      opCount++;
      expQ.push_back(entry);
    end
    pending = expQ.size();
  end

endmodule

// ==== testbench/mpModAdder_assert.sv ====
`include "mp_settings.svh"

module mpModAdderAssert
(
  input logic             clk,
  input logic             rstN,
  input logic             start,
  input logic             done,
  input mpArithPkg::wordT result
);

  int failCount = 0;

  // Second reset cycle onward.
  doneInReset: assert property (@(posedge clk) !rstN ##1 !rstN |-> !done)
    else
    begin
      failCount++;
      $error("done is high while reset is asserted");
    end

  startToDone: assert property (@(posedge clk) disable iff (!rstN)
    start |-> ##`MP_LATENCY done)
    else
    begin
      failCount++;
      $error("start was not followed by done after the pipeline latency");
    end

  doneFromStart: assert property (@(posedge clk) disable iff (!rstN)
    done |-> $past(start, `MP_LATENCY))
    else
    begin
      failCount++;
      $error("done without a start one pipeline latency earlier");
    end

  resultKnown: assert property (@(posedge clk) disable iff (!rstN)
    done |-> !$isunknown(result))
    else
    begin
      failCount++;
      $error("result has unknown bits while done is high");
    end

endmodule

// ==== hdl/mpModAdder.sv ====
`include "mp_settings.svh"

module mpModAdder
(
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  mpArithPkg::opT    op,
  input  mpArithPkg::wordT  a,
  input  mpArithPkg::wordT  b,
  input  mpArithPkg::wordT  modulus,
  output logic              done,
  output mpArithPkg::wordT  result
);

  import mpArithPkg::*;
  import mpStagePkg::*;

  // Stage 1 outputs.
  logic       prepValid;
  extWordT    prepA;
  extWordT    prepB;
  logic       prepCarry;
  sumSideT    prepSide;

  // First sum.
  logic       sumValid;
  extWordT    sumVal;
  sumSideT    sumSide;

  logic       corrValid;
  extWordT    corrA;
  extWordT    corrB;
  logic       corrCarry;
  reduceSideT corrSide;

  logic       redValid;
  extWordT    redSum;     // Corrected candidate t.
  reduceSideT redSide;

  operandPrep uPrep
  (
    .clk     (clk),
    .rstN    (rstN),
    .start   (start),
    .op      (op),
    .a       (a),
    .b       (b),
    .modulus (modulus),
    .valid   (prepValid),
    .opA     (prepA),
    .opB     (prepB),
    .carryIn (prepCarry),
    .side    (prepSide)
  );

  carrySelectAdder #(.WIDTH(`MP_WIDTH + 1), .SEG_WIDTH(`MP_SEG_WIDTH), .sideT(sumSideT)) uSum
  (
    .clk      (clk),
    .rstN     (rstN),
    .validIn  (prepValid),
    .x        (prepA),
    .y        (prepB),
    .carryIn  (prepCarry),
    .sideIn   (prepSide),
    .validOut (sumValid),
    .sum      (sumVal),
    .sideOut  (sumSide)
  );

  reductionPrep uRedPrep
  (
    .clk       (clk),
    .rstN      (rstN),
    .validIn   (sumValid),
    .sum       (sumVal),
    .sideIn    (sumSide),
    .validOut  (corrValid),
    .corrA     (corrA),
    .corrB     (corrB),
    .corrCarry (corrCarry),
    .side      (corrSide)
  );

  carrySelectAdder #(.WIDTH(`MP_WIDTH + 1), .SEG_WIDTH(`MP_SEG_WIDTH), .sideT(reduceSideT))
    uReduce
  (
    .clk      (clk),
    .rstN     (rstN),
    .validIn  (corrValid),
    .x        (corrA),
    .y        (corrB),
    .carryIn  (corrCarry),
    .sideIn   (corrSide),
    .validOut (redValid),
    .sum      (redSum),
    .sideOut  (redSide)
  );

  resultSelect uSel
  (
    .clk       (clk),
    .rstN      (rstN),
    .validIn   (redValid),
    .corrected (redSum),
    .side      (redSide),
    .done      (done),
    .result    (result)
  );

endmodule

// ==== hdl/resultSelect.sv ====
`include "mp_settings.svh"

module resultSelect
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    validIn,
  input  mpArithPkg::extWordT     corrected,
  input  mpStagePkg::reduceSideT  side,
  output logic                    done,
  output mpArithPkg::wordT        result
);

  import mpArithPkg::*;

  logic    useCorr;
  extWordT chosen;

  // Add mode keeps t unless s - n went negative. Sub mode fixes only a negative s.
  assign useCorr = (side.op == OP_ADD) ? ~corrected[`MP_WIDTH] : side.partial[`MP_WIDTH];
  assign chosen  = useCorr ? corrected : side.partial;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      done <= 1'b0;
    else
      done <= validIn;
  end

  always_ff @(posedge clk)
  begin
    if (validIn)
      result <= chosen[`MP_WIDTH-1:0];
  end

endmodule

// ==== hdl/reductionPrep.sv ====
module reductionPrep
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    validIn,
  input  mpArithPkg::extWordT     sum,
  input  mpStagePkg::sumSideT     sideIn,
  output logic                    validOut,
  output mpArithPkg::extWordT     corrA,
  output mpArithPkg::extWordT     corrB,
  output logic                    corrCarry,
  output mpStagePkg::reduceSideT  side
);

  import mpArithPkg::*;

  logic    isAdd;
  extWordT modExt;

  assign isAdd  = (sideIn.op == OP_ADD);
  assign modExt = {1'b0, sideIn.modulus};

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      validOut <= 1'b0;
    else
      validOut <= validIn;
  end

  // Add mode tries s - n and subtract mode tries s + n.
  always_ff @(posedge clk)
  begin
    if (validIn)
    begin
      corrA        <= sum;
      corrB        <= isAdd ? ~modExt : modExt;
      corrCarry    <= isAdd;
      side.op      <= sideIn.op;
      side.partial <= sum;
    end
  end

endmodule

// ==== hdl/carrySelectAdder.sv ====
`include "mp_settings.svh"

module carrySelectAdder
#(
  parameter int  WIDTH     = `MP_WIDTH + 1,
  parameter int  SEG_WIDTH = `MP_SEG_WIDTH,
  parameter type sideT     = logic
)
(
  input  logic             clk,
  input  logic             rstN,
  input  logic             validIn,
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  input  logic             carryIn,
  input  sideT             sideIn,
  output logic             validOut,
  output logic [WIDTH-1:0] sum,
  output sideT             sideOut
);

  // Last segment takes whatever is left over.
  localparam int NUM_SEG = (WIDTH >= SEG_WIDTH) ? WIDTH / SEG_WIDTH : 1;
  localparam int NCARRY  = (NUM_SEG > 1) ? NUM_SEG - 1 : 1;

  logic [WIDTH-1:0]  sum0;    // Candidate for carry-in 0.
  logic [WIDTH-1:0]  sum1;    // Candidate for carry-in 1.
  logic [NCARRY-1:0] carry0;
  logic [NCARRY-1:0] carry1;

  logic [WIDTH-1:0]  sum0Q;
  logic [WIDTH-1:0]  sum1Q;
  logic [NCARRY-1:0] carry0Q;
  logic [NCARRY-1:0] carry1Q;
  logic              carryInQ;
  logic              validQ;
  sideT              sideQ;

  logic [NUM_SEG-1:0] segCin;
  logic [WIDTH-1:0]   selSum;

  for (genvar i = 0; i < NUM_SEG; i++)
  begin : gSeg
    localparam int LSB = i * SEG_WIDTH;
    localparam int W   = (i == NUM_SEG - 1) ? WIDTH - LSB : SEG_WIDTH;

    if (i < NUM_SEG - 1)
    begin : gMid
      assign {carry0[i], sum0[LSB +: W]} = x[LSB +: W] + y[LSB +: W];
      assign {carry1[i], sum1[LSB +: W]} = x[LSB +: W] + y[LSB +: W] + 1'b1;
    end
    else
    begin : gTop
      // Carry out of the top is dropped.
      assign sum0[LSB +: W] = x[LSB +: W] + y[LSB +: W];
      assign sum1[LSB +: W] = x[LSB +: W] + y[LSB +: W] + 1'b1;
    end

    assign selSum[LSB +: W] = segCin[i] ? sum1Q[LSB +: W] : sum0Q[LSB +: W];
  end

  // Select chain over the registered carries.
  assign segCin[0] = carryInQ;

  for (genvar i = 1; i < NUM_SEG; i++)
  begin : gChain
    assign segCin[i] = segCin[i-1] ? carry1Q[i-1] : carry0Q[i-1];
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      validQ   <= 1'b0;
      validOut <= 1'b0;
    end
    else
    begin
      validQ   <= validIn;
      validOut <= validQ;
    end
  end

  // First cycle.
  always_ff @(posedge clk)
  begin
    if (validIn)
    begin
      sum0Q    <= sum0;
      sum1Q    <= sum1;
      carry0Q  <= carry0;
      carry1Q  <= carry1;
      carryInQ <= carryIn;
      sideQ    <= sideIn;
    end
  end

  always_ff @(posedge clk)
  begin
    if (validQ)
    begin
      sum     <= selSum;  // Resolved sum.
      sideOut <= sideQ;
    end
  end

endmodule

// ==== hdl/operandPrep.sv ====
module operandPrep
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 start,
  input  mpArithPkg::opT       op,
  input  mpArithPkg::wordT     a,
  input  mpArithPkg::wordT     b,
  input  mpArithPkg::wordT     modulus,
  output logic                 valid,
  output mpArithPkg::extWordT  opA,
  output mpArithPkg::extWordT  opB,
  output logic                 carryIn,
  output mpStagePkg::sumSideT  side
);

  import mpArithPkg::*;

  logic isSub;

  assign isSub = (op == OP_SUB);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      valid <= 1'b0;
    else
      valid <= start;
  end

  // Subtraction as a + ~b + 1.
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      opA          <= {1'b0, a};
      opB          <= isSub ? ~{1'b0, b} : {1'b0, b};
      carryIn      <= isSub;
      side.op      <= op;
      side.modulus <= modulus;
    end
  end

endmodule

// ==== hdl/mpStagePkg.sv ====
package mpStagePkg;

  // Travels with the first addition.
  typedef struct packed
  {
    mpArithPkg::opT   op;
    mpArithPkg::wordT modulus;
  } sumSideT;

  // Travels with the correction addition.
  typedef struct packed
  {
    mpArithPkg::opT      op;
    mpArithPkg::extWordT partial;  // Uncorrected first sum.
  } reduceSideT;

endpackage

// ==== hdl/mpArithPkg.sv ====
`include "mp_settings.svh"

package mpArithPkg;

  // Operation code of the modular adder.
  typedef enum logic
  {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } opT;

  typedef logic [`MP_WIDTH-1:0] wordT;  // Plain operand.

  // One extra bit on top for carry or sign.
  typedef logic [`MP_WIDTH:0] extWordT;

endpackage

// ==== hdl/mp_settings.svh ====
`ifndef MP_SETTINGS_SVH
`define MP_SETTINGS_SVH

// Operand width in bits.
`define MP_WIDTH 1024

// Carry-select segment width.
`define MP_SEG_WIDTH 64

`define MP_LATENCY 7  // Cycles from start to done.

`endif
